//--- busReadMerge.sv
`timescale 1ns/1ps

module busReadMerge (
	input logic clk,
	input logic arstN,
	input gpioPkg::busResponse_t bank0,
	input gpioPkg::busResponse_t bank1,
	output gpioPkg::busResponse_t response
);

	logic [31:0] mergedData;

	//////////////////////////////////////////////////////////////////////
	// response select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (bank0.request)
			mergedData = bank0.data;
		else if (bank1.request)
			mergedData = bank1.data;
		else
			mergedData = '1;    // idle bus reads as all ones
	end

	assign response.request = bank0.request || bank1.request;
	assign response.data = mergedData;

	// bank ids differ, so a single read can only ever hit one bank
	assert property (
		@(posedge clk) disable iff (!arstN)
		!(bank0.request && bank1.request)
	) else $error("both banks returned read data in the same cycle");

endmodule

//--- gpio.sv
`timescale 1ns/1ps
`include "gpio_defines.svh"

module gpio (
	input logic clk,
	input logic arstN,
	input gpioPkg::busRequest_t bus,
	output gpioPkg::busResponse_t response,
	input gpioPkg::gpioPads_t gpioInput,
	output gpioPkg::gpioPads_t gpioOutput,
	output gpioPkg::gpioPads_t gpioOe
);

	gpioPkg::localAccess_t access;
	gpioPkg::busResponse_t bank0Response;
	gpioPkg::busResponse_t bank1Response;

	gpioPkg::bank0Pads_t bank0Input;
	gpioPkg::bank0Pads_t bank0Output;
	gpioPkg::bank0Pads_t bank0Oe;
	gpioPkg::bank1Pads_t bank1Input;
	gpioPkg::bank1Pads_t bank1Output;
	gpioPkg::bank1Pads_t bank1Oe;

	//////////////////////////////////////////////////////////////////////
	// decode and banks
	//////////////////////////////////////////////////////////////////////

	peripheralSelect select_i (
		.bus(bus),
		.access(access)
	);

	gpioBank #(.padT(gpioPkg::bank0Pads_t), .bankId(`GPIO_BANK0_ID)) bank0_i (
		.clk(clk),
		.arstN(arstN),
		.access(access),
		.padInput(bank0Input),
		.padOutput(bank0Output),
		.padOe(bank0Oe),
		.response(bank0Response)
	);

	gpioBank #(.padT(gpioPkg::bank1Pads_t), .bankId(`GPIO_BANK1_ID)) bank1_i (
		.clk(clk),
		.arstN(arstN),
		.access(access),
		.padInput(bank1Input),
		.padOutput(bank1Output),
		.padOe(bank1Oe),
		.response(bank1Response)
	);

	busReadMerge merge_i (
		.clk(clk),
		.arstN(arstN),
		.bank0(bank0Response),
		.bank1(bank1Response),
		.response(response)
	);

	// pad split, bank 0 low
	assign bank0Input = gpioInput[`GPIO_PADS_0-1:0];
	assign bank1Input = gpioInput[`GPIO_PADS-1:`GPIO_PADS_0];
	assign gpioOutput = {bank1Output, bank0Output};
	assign gpioOe = {bank1Oe, bank0Oe};

endmodule

//--- gpioBank.sv
`timescale 1ns/1ps
`include "gpio_defines.svh"

module gpioBank #(
	parameter type padT = gpioPkg::bank0Pads_t,
	parameter logic [3:0] bankId = `GPIO_BANK0_ID
) (
	input logic clk,
	input logic arstN,
	input gpioPkg::localAccess_t access,
	input padT padInput,
	output padT padOutput,
	output padT padOe,
	output gpioPkg::busResponse_t response
);

	padT outputReg;
	padT oeReg;
	padT edgeReg;
	padT syncStage1;
	padT syncStage2;    // input register
	padT syncPrev;
	padT rising;
	padT edgeClear;

	logic bankHit;
	logic offsetValid;
	logic writeOutput;
	logic writeOe;
	logic writeEdge;
	logic readHit;
	logic [31:0] laneMask;
	logic [31:0] outputNext;
	logic [31:0] oeNext;
	logic [31:0] readWord;
	logic readValid;
	logic [31:0] readData;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	assign bankHit = access.enable && (access.bankId == bankId);

	always_comb begin
		offsetValid = 1'b1;
		readWord = '0;
		case (access.offset)
			`GPIO_REG_OUTPUT: readWord = 32'(outputReg);
			`GPIO_REG_OE: readWord = 32'(oeReg);
			`GPIO_REG_INPUT: readWord = 32'(syncStage2);
			`GPIO_REG_EDGE: readWord = 32'(edgeReg);
			default: offsetValid = 1'b0;
		endcase
	end

	assign writeOutput = bankHit && access.request.we && (access.offset == `GPIO_REG_OUTPUT);
	assign writeOe = bankHit && access.request.we && (access.offset == `GPIO_REG_OE);
	assign writeEdge = bankHit && access.request.we && (access.offset == `GPIO_REG_EDGE);
	assign readHit = bankHit && access.request.oe && offsetValid;

	//////////////////////////////////////////////////////////////////////
	// byte lane writes
	//////////////////////////////////////////////////////////////////////

	assign laneMask = {
		{8{access.request.byteSelect[3]}},
		{8{access.request.byteSelect[2]}},
		{8{access.request.byteSelect[1]}},
		{8{access.request.byteSelect[0]}}
	};

	// unselected lanes keep their old bits, upper bits fall off on truncation
	assign outputNext = (32'(outputReg) & ~laneMask) | (access.request.dataWrite & laneMask);
	assign oeNext = (32'(oeReg) & ~laneMask) | (access.request.dataWrite & laneMask);
	assign edgeClear = writeEdge ? padT'(access.request.dataWrite & laneMask) : '0;

	//////////////////////////////////////////////////////////////////////
	// input path
	//////////////////////////////////////////////////////////////////////

	// chain tracks the pads through reset so no edge is seen on release
	always_ff @(posedge clk) begin
		syncStage1 <= padInput;
		syncStage2 <= syncStage1;
		syncPrev <= syncStage2;
	end

	assign rising = syncStage2 & ~syncPrev;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outputReg <= '0;
			oeReg <= '0;
			edgeReg <= '0;
		end else begin
			if (writeOutput)
				outputReg <= padT'(outputNext);
			if (writeOe)
				oeReg <= padT'(oeNext);
			edgeReg <= (edgeReg & ~edgeClear) | rising;   // a new edge wins over clear
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read response
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			readValid <= 1'b0;
		else
			readValid <= readHit;   // high for exactly one cycle per read
	end

	always_ff @(posedge clk) begin
		if (readHit)
			readData <= readWord;
	end

	assign response = '{request: readValid, data: readData};
	assign padOutput = outputReg;
	assign padOe = oeReg;

endmodule

//--- gpioPkg.sv
`include "gpio_defines.svh"

package gpioPkg;

	// one cycle of the peripheral bus
	typedef struct packed {
		logic we;
		logic oe;
		logic [23:0] address;
		logic [3:0] byteSelect;
		logic [31:0] dataWrite;
	} busRequest_t;

	typedef struct packed {
		logic request;      // read valid, one cycle
		logic [31:0] data;  // all ones when idle
	} busResponse_t;

	// decoded access shared by both banks
	typedef struct packed {
		logic enable;       // peripheral id matched
		logic [3:0] bankId;
		logic [11:0] offset;
		busRequest_t request;
	} localAccess_t;

	typedef logic [`GPIO_PADS_0-1:0] bank0Pads_t;
	typedef logic [`GPIO_PADS_1-1:0] bank1Pads_t;
	typedef logic [`GPIO_PADS-1:0] gpioPads_t;

endpackage

//--- gpio_defines.svh
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// pad counts, bank 0 sits in the low bits
`define GPIO_PADS           38
`define GPIO_PADS_0         16
`define GPIO_PADS_1         22

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

`define GPIO_PERIPHERAL_ID  8'h03   // address[23:16]
`define GPIO_BANK0_ID       4'h1    // address[15:12]
`define GPIO_BANK1_ID       4'h2

// register offsets within a bank, address[11:0]
`define GPIO_REG_OUTPUT     12'h000
`define GPIO_REG_OE         12'h004
`define GPIO_REG_INPUT      12'h008 // read only
`define GPIO_REG_EDGE       12'h00C // write ones to clear

`endif

//--- peripheralSelect.sv
`timescale 1ns/1ps
`include "gpio_defines.svh"

module peripheralSelect (
	input gpioPkg::busRequest_t bus,
	output gpioPkg::localAccess_t access
);

	logic idMatch;

	//////////////////////////////////////////////////////////////////////
	// peripheral id check
	//////////////////////////////////////////////////////////////////////

	assign idMatch = (bus.address[23:16] == `GPIO_PERIPHERAL_ID);

	// the banks see the split address and the raw request
	always_comb begin
		access.enable = idMatch;
		access.bankId = bus.address[15:12];   // bank select nibble
		access.offset = bus.address[11:0];    // register within the bank
		access.request = bus;
	end

	// note that strobes pass through untouched even when the id misses,
	// each bank gates them with enable itself so the decode stays
	// a single level of logic in front of both banks

endmodule

//--- project.f
+incdir+.
gpioPkg.sv
peripheralSelect.sv
gpioBank.sv
busReadMerge.sv
gpio.sv
tb_gpio_assert.sv
tb_gpio.sv

//--- tb_gpio.sv
`timescale 1ns/1ps
`include "gpio_defines.svh"

module tb_gpio;

	logic clk = 1'b0;
	logic arstN;
	gpioPkg::busRequest_t bus;
	gpioPkg::busResponse_t response;
	gpioPkg::gpioPads_t gpioInput;
	gpioPkg::gpioPads_t gpioOutput;
	gpioPkg::gpioPads_t gpioOe;

	int errorCount = 0;
	logic [31:0] lcgState = 32'h476eaf18;
	gpioPkg::bank0Pads_t out0 = '0;    // expected register contents
	gpioPkg::bank0Pads_t oe0 = '0;
	gpioPkg::bank1Pads_t out1 = '0;
	gpioPkg::bank1Pads_t oe1 = '0;
	gpioPkg::gpioPads_t edgeExp = '0;   // expected sticky flags, both banks

	gpio dut_i (
		.clk(clk),
		.arstN(arstN),
		.bus(bus),
		.response(response),
		.gpioInput(gpioInput),
		.gpioOutput(gpioOutput),
		.gpioOe(gpioOe)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [23:0] regAddress(logic [3:0] bankId, logic [11:0] offset);
		return {`GPIO_PERIPHERAL_ID, bankId, offset};
	endfunction

	// lanes with a clear select bit keep their old byte
	function automatic logic [31:0] mergeLanes(logic [31:0] old, logic [31:0] data,
			logic [3:0] sel);
		logic [31:0] result;
		result = old;
		for (int i = 0; i < 4; i++)
			if (sel[i])
				result[i*8 +: 8] = data[i*8 +: 8];
		return result;
	endfunction

	task automatic checkResponse(string name, gpioPkg::busResponse_t expected,
			gpioPkg::busResponse_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s: expected request %b data %h, actual request %b data %h",
				name, expected.request, expected.data, actual.request, actual.data);
		end
	endtask

	task automatic checkPads(string name, gpioPkg::gpioPads_t expected,
			gpioPkg::gpioPads_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic busWrite(logic [3:0] bankId, logic [11:0] offset, logic [31:0] data,
			logic [3:0] sel);
		gpioPkg::busRequest_t req;
		req = '0;
		req.we = 1'b1;
		req.address = regAddress(bankId, offset);
		req.byteSelect = sel;
		req.dataWrite = data;
		@(posedge clk);
		bus <= req;
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
	endtask

	task automatic busRead(logic [23:0] address, bit expectReply,
			output gpioPkg::busResponse_t resp);
		gpioPkg::busRequest_t req;
		bit seen;
		req = '0;
		req.oe = 1'b1;
		req.address = address;
		seen = 1'b0;
		resp = '0;
		@(posedge clk);
		bus <= req;
		@(posedge clk);
		bus <= '0;
		for (int n = 0; n < 8 && !seen; n++) begin
			@(negedge clk);
			if (response.request) begin
				seen = 1'b1;
				resp = response;
			end
		end
		if (expectReply && !seen) begin
			errorCount++;
			$display("no read response within 8 cycles for address %h", address);
		end else if (!expectReply && seen) begin
			errorCount++;
			$display("read of unmatched address %h got a response", address);
		end
	endtask

	task automatic readAndCompare(string name, logic [3:0] bankId, logic [11:0] offset,
			logic [31:0] data);
		gpioPkg::busResponse_t resp;
		gpioPkg::busResponse_t expResp;
		expResp.request = 1'b1;
		expResp.data = data;
		busRead(regAddress(bankId, offset), 1'b1, resp);
		if (resp.request)
			checkResponse(name, expResp, resp);
	endtask

	task automatic readAllRegisters(string name);
		readAndCompare(name, `GPIO_BANK0_ID, `GPIO_REG_OUTPUT, 32'(out0));
		readAndCompare(name, `GPIO_BANK0_ID, `GPIO_REG_OE, 32'(oe0));
		readAndCompare(name, `GPIO_BANK0_ID, `GPIO_REG_INPUT, 32'(gpioInput[`GPIO_PADS_0-1:0]));
		readAndCompare(name, `GPIO_BANK0_ID, `GPIO_REG_EDGE, 32'(edgeExp[`GPIO_PADS_0-1:0]));
		readAndCompare(name, `GPIO_BANK1_ID, `GPIO_REG_OUTPUT, 32'(out1));
		readAndCompare(name, `GPIO_BANK1_ID, `GPIO_REG_OE, 32'(oe1));
		readAndCompare(name, `GPIO_BANK1_ID, `GPIO_REG_INPUT,
			32'(gpioInput[`GPIO_PADS-1:`GPIO_PADS_0]));
		readAndCompare(name, `GPIO_BANK1_ID, `GPIO_REG_EDGE,
			32'(edgeExp[`GPIO_PADS-1:`GPIO_PADS_0]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetState();
		checkPads("reset output", '0, gpioOutput);
		checkPads("reset enable", '0, gpioOe);
		readAllRegisters("reset registers");   // input reads the level held in reset
	endtask

	task automatic outputWrite();
		logic [31:0] data;
		logic [3:0] sel;
		for (int i = 0; i < 4; i++) begin
			data = lcgNext();
			sel = 4'(lcgNext() >> 28);
			busWrite(`GPIO_BANK0_ID, `GPIO_REG_OUTPUT, data, sel);
			out0 = gpioPkg::bank0Pads_t'(mergeLanes(32'(out0), data, sel));
			data = lcgNext();
			sel = 4'(lcgNext() >> 28);
			busWrite(`GPIO_BANK0_ID, `GPIO_REG_OE, data, sel);
			oe0 = gpioPkg::bank0Pads_t'(mergeLanes(32'(oe0), data, sel));
			data = lcgNext();
			sel = 4'(lcgNext() >> 28);
			busWrite(`GPIO_BANK1_ID, `GPIO_REG_OUTPUT, data, sel);
			out1 = gpioPkg::bank1Pads_t'(mergeLanes(32'(out1), data, sel));
			data = lcgNext();
			sel = 4'(lcgNext() >> 28);
			busWrite(`GPIO_BANK1_ID, `GPIO_REG_OE, data, sel);
			oe1 = gpioPkg::bank1Pads_t'(mergeLanes(32'(oe1), data, sel));
			checkPads("write output pads", {out1, out0}, gpioOutput);
			checkPads("write enable pads", {oe1, oe0}, gpioOe);
		end
		readAllRegisters("write readback");
	endtask

	task automatic inputRead();
		gpioPkg::gpioPads_t pads;
		pads = gpioPkg::gpioPads_t'({lcgNext(), lcgNext()});
		edgeExp = edgeExp | (pads & ~gpioInput);   // low to high pads raise flags
		@(posedge clk);
		gpioInput <= pads;
		repeat (3) @(posedge clk);   // two sync stages plus one
		readAllRegisters("input read");
	endtask

	task automatic edgeCaptureClear();
		gpioPkg::gpioPads_t raise;
		logic [31:0] clr0;
		logic [31:0] clr1;
		@(posedge clk);
		gpioInput <= '0;
		repeat (4) @(posedge clk);
		busWrite(`GPIO_BANK0_ID, `GPIO_REG_EDGE, '1, 4'hF);
		busWrite(`GPIO_BANK1_ID, `GPIO_REG_EDGE, '1, 4'hF);
		raise = gpioPkg::gpioPads_t'({lcgNext(), lcgNext()});
		@(posedge clk);
		gpioInput <= raise;
		edgeExp = raise;
		repeat (4) @(posedge clk);
		readAndCompare("edge capture", `GPIO_BANK0_ID, `GPIO_REG_EDGE,
			32'(raise[`GPIO_PADS_0-1:0]));
		readAndCompare("edge capture", `GPIO_BANK1_ID, `GPIO_REG_EDGE,
			32'(raise[`GPIO_PADS-1:`GPIO_PADS_0]));
		clr0 = lcgNext();
		clr1 = lcgNext();
		busWrite(`GPIO_BANK0_ID, `GPIO_REG_EDGE, clr0, 4'hF);
		busWrite(`GPIO_BANK1_ID, `GPIO_REG_EDGE, clr1, 4'hF);
		edgeExp = raise & ~{clr1[`GPIO_PADS_1-1:0], clr0[`GPIO_PADS_0-1:0]};
		readAllRegisters("edge clear");
	endtask

	task automatic unmatchedAccess();
		gpioPkg::busResponse_t resp;
		busRead({8'h04, `GPIO_BANK0_ID, `GPIO_REG_OUTPUT}, 1'b0, resp);
		busRead({`GPIO_PERIPHERAL_ID, 4'h3, `GPIO_REG_OUTPUT}, 1'b0, resp);
		busRead(regAddress(`GPIO_BANK1_ID, 12'h010), 1'b0, resp);
		busWrite(`GPIO_BANK0_ID, `GPIO_REG_INPUT, lcgNext(), 4'hF);   // read only
		busWrite(`GPIO_BANK1_ID, `GPIO_REG_INPUT, lcgNext(), 4'hF);
		readAllRegisters("input write ignored");
	endtask

	task automatic backToBackReads();
		gpioPkg::busRequest_t reqs [3];
		gpioPkg::busResponse_t expResp [3];
		for (int i = 0; i < 3; i++) begin
			reqs[i] = '0;
			reqs[i].oe = 1'b1;
			expResp[i].request = 1'b1;
		end
		reqs[0].address = regAddress(`GPIO_BANK0_ID, `GPIO_REG_OUTPUT);
		expResp[0].data = 32'(out0);
		reqs[1].address = regAddress(`GPIO_BANK1_ID, `GPIO_REG_OUTPUT);
		expResp[1].data = 32'(out1);
		reqs[2].address = regAddress(`GPIO_BANK0_ID, `GPIO_REG_OE);
		expResp[2].data = 32'(oe0);
		@(posedge clk);
		bus <= reqs[0];
		for (int i = 1; i <= 3; i++) begin
			@(posedge clk);
			if (i < 3)
				bus <= reqs[i];
			else
				bus <= '0;
			@(negedge clk);
			checkResponse("back to back", expResp[i-1], response);   // previous read lands here
		end
	endtask

	initial begin
		arstN = 1'b0;
		bus = '0;
		gpioInput = gpioPkg::gpioPads_t'({lcgNext(), lcgNext()});
		repeat (16) @(posedge clk);
		arstN <= 1'b1;
		resetState();
		outputWrite();
		inputRead();
		edgeCaptureClear();
		unmatchedAccess();
		backToBackReads();
		$display("check errors: %0d, assertion errors: %0d", errorCount,
			dut_i.assert_i.failCount);
		if (errorCount == 0 && dut_i.assert_i.failCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- tb_gpio_assert.sv
`timescale 1ns/1ps

module tb_gpio_assert (
	input logic clk,
	input logic arstN,
	input gpioPkg::busRequest_t bus,
	input gpioPkg::busResponse_t response,
	input gpioPkg::gpioPads_t gpioOe
);

	int failCount = 0;   // failed assertion evaluations

	//////////////////////////////////////////////////////////////////////
	// bus response
	//////////////////////////////////////////////////////////////////////

	idleData: assert property (
		@(posedge clk) disable iff (!arstN)
		!response.request |-> response.data == '1   // idle bus reads as all ones
	) else begin
		failCount++;
		$error("response data is not all ones while request is low");
	end

	// a second valid cycle in a row needs a read issued right before it
	validPulse: assert property (
		@(posedge clk) disable iff (!arstN)
		response.request && $past(response.request) |-> $past(bus.oe)
	) else begin
		failCount++;
		$error("request stayed high without a read on the previous cycle");
	end

	resetOe: assert property (
		@(posedge clk)
		!arstN |-> gpioOe == '0
	) else begin
		failCount++;
		$error("output enables are not zero while reset is held");
	end

endmodule

bind gpio tb_gpio_assert assert_i (
	.clk(clk),
	.arstN(arstN),
	.bus(bus),
	.response(response),
	.gpioOe(gpioOe)
);
